//--- ackTimer.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module ackTimer (
	input  wire logic dCacheCoreBus,
	input  wire logic arstN,
	input  wire logic timerRun,
	output logic      timedOut
);

	localparam int cntBits = $clog2(`WB_ACK_TIMEOUT + 1);
	localparam logic [cntBits-1:0] lastCount = cntBits'(`WB_ACK_TIMEOUT - 1);

	logic [cntBits-1:0] count;

	// counts waiting cycles, restarts whenever the wait is over
	always_ff @(posedge dCacheCoreBus or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (!timerRun) begin
			count <= '0;
		end else if (count != lastCount) begin
			count <= count + 1'b1;
		end
	end

	// last allowed waiting cycle
	assign timedOut = timerRun && (count == lastCount);

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
writeBackPkg.sv
ackTimer.sv
memWriteFsm.sv
regScoreboard.sv
writeBack.sv
writeBackStage.sv
writeBackStage_properties.sv
writeBackStage_tb.sv

//--- memWriteFsm.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteFsm (
	input  wire logic dCacheCoreBus,
	input  wire logic arstN,
	input  wire logic storeStart,
	input  wire logic reqAck,
	input  wire logic timedOut,
	output logic      reqCyc,
	output logic      storeActive,
	output logic      storeDone,
	output logic      storeFault,
	output logic      timerRun,
	output logic      memFault
);

	writeBackPkg::storeStateE state;
	writeBackPkg::storeStateE stateNext;
	logic isActive;

	assign isActive = (state == writeBackPkg::stActive);

	// ack wins over a timeout in the same cycle
	assign storeDone  = isActive && reqAck;
	assign storeFault = isActive && !reqAck && timedOut;

	always_comb begin
		stateNext = state;
		case (state)
			writeBackPkg::stIdle: begin
				if (storeStart) begin
					stateNext = writeBackPkg::stActive;
				end
			end
			writeBackPkg::stActive: begin
				if (storeDone || storeFault) begin
					stateNext = writeBackPkg::stIdle;
				end
			end
			default: begin
				stateNext = writeBackPkg::stIdle;
			end
		endcase
	end

	always_ff @(posedge dCacheCoreBus or negedge arstN) begin
		if (!arstN) begin
			state <= writeBackPkg::stIdle;
		end else begin
			state <= stateNext;
		end
	end

	// one-cycle fault pulse, the cycle after the store is dropped
	always_ff @(posedge dCacheCoreBus or negedge arstN) begin
		if (!arstN) begin
			memFault <= 1'b0;
		end else begin
			memFault <= storeFault;
		end
	end

	// request level follows the active state
	assign reqCyc      = isActive;
	assign storeActive = isActive;
	assign timerRun    = isActive;

endmodule

`default_nettype wire

//--- regScoreboard.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module regScoreboard (
	input  wire logic                     dCacheCoreBus,
	input  wire logic                     arstN,
	input  wire logic                     regWrEn,
	input  wire logic [`WB_REG_BITS-1:0]  regWrAddr,
	input  wire logic [`WB_DATA_BITS-1:0] regWrData,
	input  wire logic                     specWrEn,
	input  wire logic [`WB_REG_BITS-1:0]  specWrAddr,
	input  wire logic [`WB_DATA_BITS-1:0] specWrData,
	input  wire logic [`WB_NUM_REGS-1:0]  clearMask,
	input  wire logic                     setInUse,
	input  wire logic [`WB_REG_BITS-1:0]  setInUseReg,
	input  wire logic [`WB_REG_BITS-1:0]  readAddr,
	output logic      [`WB_DATA_BITS-1:0] readData,
	output logic      [`WB_NUM_REGS-1:0]  inUseMap
);

	logic [`WB_DATA_BITS-1:0] regFile [`WB_NUM_REGS];
	logic [`WB_NUM_REGS-1:0]  inUse;
	logic [`WB_NUM_REGS-1:0]  setMask;

	// registers read zero after reset
	always_ff @(posedge dCacheCoreBus or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `WB_NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else begin
			// special first so the alu result wins on a shared index
			if (specWrEn) begin
				regFile[specWrAddr] <= specWrData;
			end
			if (regWrEn) begin
				regFile[regWrAddr] <= regWrData;
			end
		end
	end

	always_comb begin
		setMask = '0;
		if (setInUse) begin
			setMask[setInUseReg] = 1'b1;
		end
	end

	// issue-side set beats a retirement clear
	always_ff @(posedge dCacheCoreBus or negedge arstN) begin
		if (!arstN) begin
			inUse <= '0;
		end else begin
			inUse <= (inUse & ~clearMask) | setMask;
		end
	end

	assign readData = regFile[readAddr];
	assign inUseMap = inUse;

endmodule

`default_nettype wire

//--- writeBack.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module writeBack (
	input  wire logic                      dCacheCoreBus,
	input  wire logic                      canWriteBack,
	input  wire logic                      kill,
	input  wire logic [`WB_REG_BITS-1:0]   srcReg1,
	input  wire logic                      srcReg1Valid,
	input  wire logic [`WB_REG_BITS-1:0]   srcReg2,
	input  wire logic                      srcReg2Valid,
	input  wire logic [`WB_REG_BITS-1:0]   destReg,
	input  wire logic [`WB_REG_BITS-1:0]   destRegSpecial,
	input  wire logic                      destRegSpecialValid,
	input  wire logic                      isMemDest,
	input  wire logic [`WB_ADDR_BITS-1:0]  memAddrDest,
	input  wire logic [`WB_DATA_BITS-1:0]  aluResult,
	input  wire logic [`WB_DATA_BITS-1:0]  aluResultSpecial,
	input  wire logic                      storeActive,
	input  wire logic                      storeDone,
	input  wire logic                      storeFault,
	output logic                           regWrEn,
	output logic      [`WB_REG_BITS-1:0]   regWrAddr,
	output logic      [`WB_DATA_BITS-1:0]  regWrData,
	output logic                           specWrEn,
	output logic      [`WB_REG_BITS-1:0]   specWrAddr,
	output logic      [`WB_DATA_BITS-1:0]  specWrData,
	output logic      [`WB_NUM_REGS-1:0]   clearMask,
	output logic                           storeStart,
	output logic      [`WB_ADDR_BITS-1:0]  reqAddr,
	output logic      [`WB_DATA_BITS-1:0]  reqData,
	output writeBackPkg::reqTagT           reqTag,
	output logic                           stallOnMemWr,
	output logic                           writeBackSuccessful
);

	logic isStore;
	logic storeEnd;
	logic retire;
	writeBackPkg::reqTagT storeTag;

	// killed slots never touch memory
	assign isStore  = isMemDest && !kill;
	assign storeEnd = storeDone || storeFault;

	// a store retires only on the cycle its request finishes
	assign retire = canWriteBack && (!isStore || storeEnd);
	assign writeBackSuccessful = retire;
	assign stallOnMemWr = canWriteBack && isStore && !storeEnd;

	// launch once from idle, the held slot must not relaunch on its end cycle
	assign storeStart = canWriteBack && isStore && !storeActive;

	assign regWrEn   = retire && !kill && !isMemDest;
	assign regWrAddr = destReg;
	assign regWrData = aluResult;

	assign specWrEn   = retire && !kill && destRegSpecialValid;
	assign specWrAddr = destRegSpecial;
	assign specWrData = aluResultSpecial;

	always_comb begin
		clearMask = '0;
		if (retire) begin
			if (srcReg1Valid) begin
				clearMask[srcReg1] = 1'b1;
			end
			if (srcReg2Valid) begin
				clearMask[srcReg2] = 1'b1;
			end
			if (destRegSpecialValid) begin
				clearMask[destRegSpecial] = 1'b1;
			end
			clearMask[destReg] = 1'b1;
		end
	end

	// data write to memory
	always_comb begin
		storeTag        = '0;
		storeTag.dir    = writeBackPkg::dirWrite;
		storeTag.target = writeBackPkg::targetMemory;
		storeTag.kind   = writeBackPkg::kindData;
	end

	// request fields stay put while reqCyc is up
	always_ff @(posedge dCacheCoreBus) begin
		if (storeStart) begin
			reqAddr <= memAddrDest;
			reqData <= aluResult;
			reqTag  <= storeTag;
		end
	end

endmodule

`default_nettype wire

//--- writeBackPkg.sv
`default_nettype none

package writeBackPkg;

	// request direction
	typedef enum logic [0:0] {
		dirRead  = 1'b0,
		dirWrite = 1'b1
	} reqDirE;

	// request target
	typedef enum logic [0:0] {
		targetMemory = 1'b0,
		targetIo     = 1'b1
	} reqTargetE;

	// request kind
	typedef enum logic [0:0] {
		kindData  = 1'b0,
		kindInstr = 1'b1
	} reqKindE;

	// ten-bit cache request tag, msb first
	typedef struct packed {
		reqDirE    dir;
		reqTargetE target;
		reqKindE   kind;
		logic [6:0] zero;
	} reqTagT;

	// store sequencer state
	typedef enum logic [0:0] {
		stIdle   = 1'b0,
		stActive = 1'b1
	} storeStateE;

endpackage

`default_nettype wire

//--- writeBackStage.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module writeBackStage (
	input  wire logic                      dCacheCoreBus,
	input  wire logic                      arstN,
	input  wire logic                      canWriteBack,
	input  wire logic                      kill,
	input  wire logic [`WB_REG_BITS-1:0]   srcReg1,
	input  wire logic                      srcReg1Valid,
	input  wire logic [`WB_REG_BITS-1:0]   srcReg2,
	input  wire logic                      srcReg2Valid,
	input  wire logic [`WB_REG_BITS-1:0]   destReg,
	input  wire logic [`WB_REG_BITS-1:0]   destRegSpecial,
	input  wire logic                      destRegSpecialValid,
	input  wire logic                      isMemDest,
	input  wire logic [`WB_ADDR_BITS-1:0]  memAddrDest,
	input  wire logic [`WB_DATA_BITS-1:0]  aluResult,
	input  wire logic [`WB_DATA_BITS-1:0]  aluResultSpecial,
	input  wire logic                      setInUse,
	input  wire logic [`WB_REG_BITS-1:0]   setInUseReg,
	input  wire logic [`WB_REG_BITS-1:0]   readAddr,
	input  wire logic                      reqAck,
	output logic      [`WB_DATA_BITS-1:0]  readData,
	output logic      [`WB_NUM_REGS-1:0]   inUseMap,
	output logic                           reqCyc,
	output logic      [`WB_ADDR_BITS-1:0]  reqAddr,
	output logic      [`WB_DATA_BITS-1:0]  reqData,
	output writeBackPkg::reqTagT           reqTag,
	output logic                           stallOnMemWr,
	output logic                           writeBackSuccessful,
	output logic                           memFault
);

	logic                     regWrEn;
	logic [`WB_REG_BITS-1:0]  regWrAddr;
	logic [`WB_DATA_BITS-1:0] regWrData;
	logic                     specWrEn;
	logic [`WB_REG_BITS-1:0]  specWrAddr;
	logic [`WB_DATA_BITS-1:0] specWrData;
	logic [`WB_NUM_REGS-1:0]  clearMask;
	logic                     storeStart;
	logic                     storeActive;
	logic                     storeDone;
	logic                     storeFault;
	logic                     timerRun;
	logic                     timedOut;

	writeBack uWriteBack (
		.dCacheCoreBus(dCacheCoreBus),
		.canWriteBack(canWriteBack),
		.kill(kill),
		.srcReg1(srcReg1),
		.srcReg1Valid(srcReg1Valid),
		.srcReg2(srcReg2),
		.srcReg2Valid(srcReg2Valid),
		.destReg(destReg),
		.destRegSpecial(destRegSpecial),
		.destRegSpecialValid(destRegSpecialValid),
		.isMemDest(isMemDest),
		.memAddrDest(memAddrDest),
		.aluResult(aluResult),
		.aluResultSpecial(aluResultSpecial),
		.storeActive(storeActive),
		.storeDone(storeDone),
		.storeFault(storeFault),
		.regWrEn(regWrEn),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData),
		.specWrEn(specWrEn),
		.specWrAddr(specWrAddr),
		.specWrData(specWrData),
		.clearMask(clearMask),
		.storeStart(storeStart),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqTag(reqTag),
		.stallOnMemWr(stallOnMemWr),
		.writeBackSuccessful(writeBackSuccessful)
	);

	memWriteFsm uMemWriteFsm (
		.dCacheCoreBus(dCacheCoreBus),
		.arstN(arstN),
		.storeStart(storeStart),
		.reqAck(reqAck),
		.timedOut(timedOut),
		.reqCyc(reqCyc),
		.storeActive(storeActive),
		.storeDone(storeDone),
		.storeFault(storeFault),
		.timerRun(timerRun),
		.memFault(memFault)
	);

	ackTimer uAckTimer (
		.dCacheCoreBus(dCacheCoreBus),
		.arstN(arstN),
		.timerRun(timerRun),
		.timedOut(timedOut)
	);

	regScoreboard uRegScoreboard (
		.dCacheCoreBus(dCacheCoreBus),
		.arstN(arstN),
		.regWrEn(regWrEn),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData),
		.specWrEn(specWrEn),
		.specWrAddr(specWrAddr),
		.specWrData(specWrData),
		.clearMask(clearMask),
		.setInUse(setInUse),
		.setInUseReg(setInUseReg),
		.readAddr(readAddr),
		.readData(readData),
		.inUseMap(inUseMap)
	);

endmodule

`default_nettype wire

//--- writeBackStage_properties.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module writeBackStage_properties (
	input wire logic dCacheCoreBus,
	input wire logic arstN,
	input wire logic reqCyc,
	input wire logic reqAck,
	input wire logic timedOut,
	input wire logic memFault
);

	// request is held until ack, or dropped on timeout
	property requestHeld;
		@(posedge dCacheCoreBus) disable iff (!arstN)
			(reqCyc && !reqAck && !timedOut) |=> reqCyc;
	endproperty

	// fault is a single-cycle pulse
	property faultSingleCycle;
		@(posedge dCacheCoreBus) disable iff (!arstN)
			memFault |=> !memFault;
	endproperty

	// no request outlives the acknowledge window
	property requestBounded;
		@(posedge dCacheCoreBus) disable iff (!arstN)
			$rose(reqCyc) |-> ##[1:`WB_ACK_TIMEOUT] !reqCyc;
	endproperty

	assertRequestHeld: assert property (requestHeld)
		else $error("reqCyc dropped while waiting for reqAck");

	assertFaultSingleCycle: assert property (faultSingleCycle)
		else $error("memFault stayed high for more than one cycle");

	assertRequestBounded: assert property (requestBounded)
		else $error("reqCyc stayed high beyond the acknowledge timeout");

endmodule

`default_nettype wire

//--- writeBackStage_tb.sv
`timescale 1ns/1ps
`include "writeBack_settings.svh"
`default_nettype none

module writeBackStage_tb;

	localparam int slotRegOnly = 0;
	localparam int slotKill = 1;
	localparam int slotStore = 2;
	localparam int numRegSlots = 40;
	localparam int numSetSlots = 30;
	localparam int numKillSlots = 20;
	localparam int numStoreSlots = 30;
	localparam int numTimeoutSlots = 4;
	localparam int retireLimit = `WB_ACK_TIMEOUT + 4;
	// four extra slots cover reset, the set batch and the register sweeps
	localparam int watchdogCycles = (numRegSlots + numSetSlots + numKillSlots
		+ numStoreSlots + numTimeoutSlots + 4) * (`WB_ACK_TIMEOUT + 4);

	logic dCacheCoreBus;
	logic arstN;
	logic canWriteBack;
	logic kill;
	logic [`WB_REG_BITS-1:0] srcReg1;
	logic srcReg1Valid;
	logic [`WB_REG_BITS-1:0] srcReg2;
	logic srcReg2Valid;
	logic [`WB_REG_BITS-1:0] destReg;
	logic [`WB_REG_BITS-1:0] destRegSpecial;
	logic destRegSpecialValid;
	logic isMemDest;
	logic [`WB_ADDR_BITS-1:0] memAddrDest;
	logic [`WB_DATA_BITS-1:0] aluResult;
	logic [`WB_DATA_BITS-1:0] aluResultSpecial;
	logic setInUse;
	logic [`WB_REG_BITS-1:0] setInUseReg;
	logic [`WB_REG_BITS-1:0] readAddr;
	logic reqAck;
	logic [`WB_DATA_BITS-1:0] readData;
	logic [`WB_NUM_REGS-1:0] inUseMap;
	logic reqCyc;
	logic [`WB_ADDR_BITS-1:0] reqAddr;
	logic [`WB_DATA_BITS-1:0] reqData;
	writeBackPkg::reqTagT reqTag;
	logic stallOnMemWr;
	logic writeBackSuccessful;
	logic memFault;

	// reference model state
	logic [`WB_DATA_BITS-1:0] expRegs [`WB_NUM_REGS];
	logic [`WB_NUM_REGS-1:0] expInUse;
	logic storeBusy;
	int waitCycles;
	logic faultPending;
	logic [`WB_ADDR_BITS-1:0] expAddr;
	logic [`WB_DATA_BITS-1:0] expData;
	logic [9:0] expTag;

	logic [31:0] rngState;
	logic monitorOn;
	logic ackSilent;
	int errCount;
	int checkCount;
	int faultCount;

	writeBackStage DUT (.*);

	bind memWriteFsm writeBackStage_properties uProperties (
		.dCacheCoreBus(dCacheCoreBus),
		.arstN(arstN),
		.reqCyc(reqCyc),
		.reqAck(reqAck),
		.timedOut(timedOut),
		.memFault(memFault)
	);

	initial begin
		dCacheCoreBus = 1'b0;
		forever #10 dCacheCoreBus = ~dCacheCoreBus;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// one clock of the reference model, evaluated mid-cycle
	task automatic modelCycle();
		logic isStore;
		logic faultNow;
		logic storeEnd;
		logic expRetire;
		logic [`WB_NUM_REGS-1:0] clr;
		isStore = canWriteBack && isMemDest && !kill;
		faultNow = storeBusy && !reqAck && (waitCycles == `WB_ACK_TIMEOUT);
		storeEnd = storeBusy && (reqAck || faultNow);
		expRetire = canWriteBack && (!isStore || storeEnd);
		checkValue("reqCyc", reqCyc, storeBusy);
		checkValue("writeBackSuccessful", writeBackSuccessful, expRetire);
		checkValue("stallOnMemWr", stallOnMemWr, isStore && !storeEnd);
		checkValue("memFault", memFault, faultPending);
		checkValue("readData", readData, expRegs[readAddr]);
		checkValue("inUseMap", inUseMap, expInUse);
		if (storeBusy) begin
			checkValue("reqAddr", reqAddr, expAddr);
			checkValue("reqData", reqData, expData);
			checkValue("reqTag", reqTag, expTag);
		end
		if (memFault) begin
			faultCount++;
		end
		clr = '0;
		if (expRetire) begin
			if (srcReg1Valid) clr[srcReg1] = 1'b1;
			if (srcReg2Valid) clr[srcReg2] = 1'b1;
			if (destRegSpecialValid) clr[destRegSpecial] = 1'b1;
			clr[destReg] = 1'b1;
			if (!kill && destRegSpecialValid) expRegs[destRegSpecial] = aluResultSpecial;
			// alu result lands last, so it wins a shared index
			if (!kill && !isMemDest) expRegs[destReg] = aluResult;
		end
		expInUse = expInUse & ~clr;
		if (setInUse) expInUse[setInUseReg] = 1'b1;
		faultPending = faultNow;
		if (storeBusy) begin
			if (storeEnd) storeBusy = 1'b0;
			else waitCycles++;
		end else if (isStore) begin
			storeBusy = 1'b1;
			waitCycles = 1;
			expAddr = memAddrDest;
			expData = aluResult;
			// write, memory, data, zero field
			expTag = {1'b1, 1'b0, 1'b0, 7'd0};
		end
	endtask

	always @(negedge dCacheCoreBus) begin
		if (monitorOn) modelCycle();
	end

	// cache side, acks after 0 to 6 cycles
	initial begin
		int unsigned delay;
		forever begin
			@(negedge dCacheCoreBus);
			if (arstN && reqCyc && !ackSilent) begin
				delay = nextRandom() % 7;
				repeat (delay) @(negedge dCacheCoreBus);
				@(posedge dCacheCoreBus);
				reqAck <= 1'b1;
				@(posedge dCacheCoreBus);
				reqAck <= 1'b0;
			end
		end
	end

	task automatic runSlot(input int mode, input bit withSet);
		logic [31:0] r;
		logic [`WB_REG_BITS-1:0] dst;
		logic [`WB_REG_BITS-1:0] spec;
		int waited;
		r = nextRandom();
		dst = r[3:0];
		spec = r[7:4];
		@(posedge dCacheCoreBus);
		canWriteBack <= 1'b1;
		kill <= (mode == slotKill);
		isMemDest <= (mode == slotStore) || (mode == slotKill && r[8]);
		srcReg1 <= r[12:9];
		srcReg1Valid <= r[13];
		srcReg2 <= r[17:14];
		srcReg2Valid <= r[18];
		destReg <= dst;
		destRegSpecial <= spec;
		destRegSpecialValid <= r[19];
		memAddrDest <= {nextRandom(), nextRandom()};
		aluResult <= {nextRandom(), nextRandom()};
		aluResultSpecial <= {nextRandom(), nextRandom()};
		setInUse <= withSet && r[20];
		// half the sets hit the register being cleared
		setInUseReg <= r[21] ? dst : r[25:22];
		readAddr <= spec;
		waited = 0;
		do begin
			@(negedge dCacheCoreBus);
			waited++;
		end while (!writeBackSuccessful && waited < retireLimit);
		assert (writeBackSuccessful) else begin
			errCount++;
			$display("slot of kind %0d did not retire within %0d cycles", mode, retireLimit);
		end
		@(posedge dCacheCoreBus);
		canWriteBack <= 1'b0;
		kill <= 1'b0;
		isMemDest <= 1'b0;
		setInUse <= withSet && r[26];
		setInUseReg <= r[30:27];
		readAddr <= dst;
		@(posedge dCacheCoreBus);
		setInUse <= 1'b0;
		readAddr <= spec;
	endtask

	task automatic sweepRegisters();
		for (int i = 0; i < `WB_NUM_REGS; i++) begin
			@(posedge dCacheCoreBus);
			readAddr <= i[`WB_REG_BITS-1:0];
		end
		@(posedge dCacheCoreBus);
	endtask

	task automatic reportTest(input string name, input int errBefore, input int chkBefore);
		$display("%s: %0d checks, %0d errors", name, checkCount - chkBefore,
			errCount - errBefore);
	endtask

	initial begin
		repeat (watchdogCycles) @(posedge dCacheCoreBus);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int errBefore;
		int chkBefore;
		int faultsBefore;
		logic [31:0] r;
		arstN = 1'b0;
		canWriteBack = 1'b0;
		kill = 1'b0;
		srcReg1 = '0;
		srcReg1Valid = 1'b0;
		srcReg2 = '0;
		srcReg2Valid = 1'b0;
		destReg = '0;
		destRegSpecial = '0;
		destRegSpecialValid = 1'b0;
		isMemDest = 1'b0;
		memAddrDest = '0;
		aluResult = '0;
		aluResultSpecial = '0;
		setInUse = 1'b0;
		setInUseReg = '0;
		readAddr = '0;
		reqAck = 1'b0;
		rngState = 32'h7127_03f0;
		monitorOn = 1'b0;
		ackSilent = 1'b0;
		errCount = 0;
		checkCount = 0;
		faultCount = 0;
		for (int i = 0; i < `WB_NUM_REGS; i++) expRegs[i] = '0;
		expInUse = '0;
		storeBusy = 1'b0;
		waitCycles = 0;
		faultPending = 1'b0;
		repeat (3) @(posedge dCacheCoreBus);
		arstN <= 1'b1;
		monitorOn = 1'b1;

		errBefore = errCount;
		chkBefore = checkCount;
		sweepRegisters();
		repeat (numRegSlots) runSlot(slotRegOnly, 1'b0);
		reportTest("test 1 reset and register writes", errBefore, chkBefore);

		errBefore = errCount;
		chkBefore = checkCount;
		// raise a batch of bits before retiring over them
		repeat (8) begin
			@(posedge dCacheCoreBus);
			r = nextRandom();
			setInUse <= 1'b1;
			setInUseReg <= r[`WB_REG_BITS-1:0];
		end
		repeat (numSetSlots) runSlot(slotRegOnly, 1'b1);
		reportTest("test 2 scoreboard", errBefore, chkBefore);

		errBefore = errCount;
		chkBefore = checkCount;
		repeat (numKillSlots) runSlot(slotKill, 1'b1);
		reportTest("test 3 kill", errBefore, chkBefore);

		errBefore = errCount;
		chkBefore = checkCount;
		repeat (numStoreSlots) runSlot(slotStore, 1'b1);
		reportTest("test 4 stores", errBefore, chkBefore);

		errBefore = errCount;
		chkBefore = checkCount;
		faultsBefore = faultCount;
		ackSilent = 1'b1;
		runSlot(slotStore, 1'b1);
		ackSilent = 1'b0;
		checkValue("memFault pulse count", faultCount - faultsBefore, 1);
		runSlot(slotStore, 1'b1);
		runSlot(slotRegOnly, 1'b1);
		runSlot(slotStore, 1'b0);
		sweepRegisters();
		reportTest("test 5 timeout", errBefore, chkBefore);

		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- writeBack_settings.svh
`ifndef WRITEBACK_SETTINGS_SVH
`define WRITEBACK_SETTINGS_SVH

`default_nettype none

// architectural integer registers
`define WB_NUM_REGS 16
`define WB_REG_BITS 4

// register and store data width
`define WB_DATA_BITS 64

// memory address width
`define WB_ADDR_BITS 64

// waiting cycles before a store is abandoned
`define WB_ACK_TIMEOUT 16

`default_nettype wire

`endif
